//--- verilog.f
+incdir+include
rtl/codePkg.sv
rtl/corrPkg.sv
rtl/codeRegDecode.sv
rtl/codeGen.sv
rtl/chipCorrelator.sv
rtl/despreader.sv
testbench/despreaderTb.sv

//--- run.sh
#!/bin/sh
# Build and run the despreader testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module despreaderTb -f verilog.f -o despreaderSim

./obj_dir/despreaderSim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- testbench/despreaderTb.sv
// **************************************************************************
// Despreader testbench: directed tests, code and correlator reference
// model, credit-returning consumer, checks and watchdog.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "codeRegMap.svh"

module despreaderTb;

    localparam int resultCredits = 4;
    localparam int clkPeriod     = 40;
    localparam int sampleBudget  = 130 + 80 + 60 + 240 + 100 + 140;  // Worst-case sample slots.
    localparam int watchdogNs    = sampleBudget * clkPeriod * 2 + 400 * clkPeriod;
    localparam int cw            = codePkg::CODE_WIDTH;

    logic                 clk;
    logic                 reset;
    logic                 regWrite;
    logic [3:0]           regAddr;
    codePkg::codeState_t  regData;
    logic                 sampleValid;
    corrPkg::sampleIq_t   sample;
    logic                 resultCredit = 1'b0;
    logic                 resultValid;
    corrPkg::corrResult_t result;
    logic                 overrun;

    codePkg::codeState_t  cfgInit;
    codePkg::codeState_t  cfgEpoch;
    codePkg::codeState_t  cfgPoly;
    codePkg::codeState_t  cfgCount;
    codePkg::codeState_t  cfgITaps;
    codePkg::codeState_t  cfgQTaps;
    codePkg::codeMode_t   cfgMode;
    codePkg::codeState_t  mLfsr;
    codePkg::codeState_t  mSec;
    codePkg::codeState_t  mCount;
    int                   mAccI;
    int                   mAccQ;
    corrPkg::corrResult_t expQ[$];
    corrPkg::corrResult_t modelLog[$];
    corrPkg::corrResult_t rxLog[$];
    corrPkg::sampleIq_t   burst[$];
    corrPkg::corrResult_t expected;
    int                   errors = 0;
    int                   rxCount = 0;
    int                   owed = 0;
    logic                 consumerOn = 1'b1;
    logic [15:0]          rngState = 16'd27149;

    despreader #(
        .codeWidth     (cw),
        .resultCredits (resultCredits)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .regWrite     (regWrite),
        .regAddr      (regAddr),
        .regData      (regData),
        .sampleValid  (sampleValid),
        .sample       (sample),
        .resultCredit (resultCredit),
        .resultValid  (resultValid),
        .result       (result),
        .overrun      (overrun)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [15:0] galoisStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            rngState = galoisStep(rngState);
            bits     = {bits[6:0], rngState[0]};
        end
        return bits;
    endfunction

    function automatic corrPkg::sampleIq_t randomSample();
        corrPkg::sampleIq_t s;
        s.sampleI = corrPkg::sample_t'(takeBits(8));
        s.sampleQ = corrPkg::sample_t'(takeBits(8));
        return s;
    endfunction

    function automatic int highestBit(input codePkg::codeState_t taps);
        for (int b = cw - 1; b >= 0; b--) begin
            if (taps[b]) return b;
        end
        return 0;
    endfunction

    function automatic codePkg::codeState_t maskOf(input codePkg::codeState_t taps);
        if (taps == '0) return '0;
        return codePkg::codeState_t'((32'd1 << (highestBit(taps) + 1)) - 32'd1);
    endfunction

    task automatic modelReload();
        mLfsr  = cfgInit;
        mSec   = cfgITaps;                                   // Gold partner seed.
        mCount = cfgCount;
    endtask

    // One chip of the generator and one product of the correlator.
    task automatic modelStep(input corrPkg::sampleIq_t s);
        int                   h;
        logic                 cI;
        logic                 cQ;
        logic                 ep;
        int                   pI;
        int                   pQ;
        corrPkg::corrResult_t r;
        h  = highestBit(cfgPoly);
        cI = ^(mLfsr & cfgITaps);
        cQ = ^(mLfsr & cfgQTaps);
        ep = ((mLfsr & maskOf(cfgPoly)) == cfgEpoch);
        if (cfgMode == codePkg::goldCode) begin
            cI = mLfsr[h] ^ mSec[h];
            cQ = cI;
        end
        if (mCount == '0) begin
            modelReload();
        end else begin
            mLfsr  = {mLfsr[cw-2:0], ^(mLfsr & cfgPoly)};
            mSec   = {mSec[cw-2:0], ^(mSec & cfgQTaps)};
            mCount = mCount - codePkg::codeState_t'(1);
        end
        pI = cI ? -int'($signed(s.sampleI)) : int'($signed(s.sampleI));
        pQ = cQ ? -int'($signed(s.sampleQ)) : int'($signed(s.sampleQ));
        if (ep) begin
            r.accI = corrPkg::acc_t'(mAccI);
            r.accQ = corrPkg::acc_t'(mAccQ);
            expQ.push_back(r);
            modelLog.push_back(r);
            mAccI = pI;
            mAccQ = pQ;
        end else begin
            mAccI += pI;
            mAccQ += pQ;
        end
    endtask

    // Result checker and credit-returning consumer.
    always @(negedge clk) begin
        if (!reset && resultValid) begin
            rxLog.push_back(result);
            rxCount++;
            owed++;
            if (expQ.size() == 0) begin
                $display("Result arrived at %0t with no model result pending", $time);
                errors++;
            end else begin
                expected = expQ.pop_front();
                checkValue("result.accI", expected.accI, result.accI);
                checkValue("result.accQ", expected.accQ, result.accQ);
            end
        end
        if (consumerOn && owed > 0) begin
            resultCredit = 1'b1;                             // One slot freed.
            owed--;
        end else begin
            resultCredit = 1'b0;
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            sampleValid = 1'b0;
        end
    endtask

    task automatic writeReg(input logic [3:0] addr, input codePkg::codeState_t data);
        @(negedge clk);
        regWrite = 1'b1;
        regAddr  = addr;
        regData  = data;
        case (addr)
            `REG_INIT:          cfgInit  = data;
            `REG_EPOCH:         cfgEpoch = data;
            `REG_POLY_TAPS:     cfgPoly  = data;
            `REG_RESTART_COUNT: cfgCount = data;
            `REG_I_TAPS:        cfgITaps = data;
            `REG_Q_TAPS:        cfgQTaps = data;
            `REG_CONTROL: begin
                cfgMode = codePkg::codeMode_t'(data[`CTRL_MODE_BIT]);
                if (data[`CTRL_RESTART_BIT]) modelReload();
            end
            default: ;
        endcase
        @(negedge clk);
        regWrite = 1'b0;
    endtask

    function automatic codePkg::codeState_t controlWord(input logic restart, input logic clear);
        codePkg::codeState_t w;
        w                      = '0;
        w[`CTRL_MODE_BIT]      = cfgMode;
        w[`CTRL_RESTART_BIT]   = restart;
        w[`CTRL_OVR_CLEAR_BIT] = clear;
        return w;
    endfunction

    task automatic configure(input codePkg::codeState_t init, input codePkg::codeState_t epoch,
                             input codePkg::codeState_t poly, input codePkg::codeState_t count,
                             input codePkg::codeState_t iTaps, input codePkg::codeState_t qTaps,
                             input codePkg::codeMode_t mode);
        writeReg(`REG_INIT, init);
        writeReg(`REG_EPOCH, epoch);
        writeReg(`REG_POLY_TAPS, poly);
        writeReg(`REG_RESTART_COUNT, count);
        writeReg(`REG_I_TAPS, iTaps);
        writeReg(`REG_Q_TAPS, qTaps);
        cfgMode = mode;
        writeReg(`REG_CONTROL, controlWord(1'b1, 1'b0));
    endtask

    task automatic sendSample(input corrPkg::sampleIq_t s, input int gap);
        @(negedge clk);
        sampleValid = 1'b1;
        sample      = s;
        modelStep(s);
        idle(gap);
    endtask

    task automatic drainResults();
        idle(4);                                             // Pipeline is two cycles deep.
        while (expQ.size() != 0 || owed != 0) @(negedge clk);
        idle(2);
    endtask

    // Restart the code and replay the stored burst.
    task automatic playBurst(input logic gapped);
        writeReg(`REG_CONTROL, controlWord(1'b1, 1'b0));
        foreach (burst[i]) sendSample(burst[i], gapped ? int'(takeBits(2)) : 0);
        drainResults();
    endtask

    // The first result of a run holds the previous run's partial sum.
    task automatic compareRuns(input int modelStart, input int rxStart, input int count);
        for (int i = 1; i < count && rxStart + i < rxLog.size(); i++) begin
            checkValue("rerun.accI", modelLog[modelStart+i].accI, rxLog[rxStart+i].accI);
            checkValue("rerun.accQ", modelLog[modelStart+i].accQ, rxLog[rxStart+i].accQ);
        end
    endtask

    task automatic testSingleMode();
        configure(18'h00001, 18'h00001, 18'h00014, 18'h3FFFF, 18'h00005, 18'h00012,
                  codePkg::singleLfsr);
        repeat (130) sendSample(randomSample(), 0);
        drainResults();
        checkValue("overrun", 0, overrun);
    endtask

    task automatic testGoldMode();
        configure(18'h00015, 18'h00015, 18'h00021, 18'd9, 18'h0002B, 18'h00030,
                  codePkg::goldCode);
        repeat (80) sendSample(randomSample(), 0);
        drainResults();
    endtask

    task automatic testSampleGaps();
        int aModel;
        int runLength;
        int bRx;
        burst.delete();
        repeat (60) burst.push_back(randomSample());
        aModel = modelLog.size();
        playBurst(1'b0);
        runLength = modelLog.size() - aModel;
        bRx = rxLog.size();
        playBurst(1'b1);
        checkValue("runLength", runLength, rxLog.size() - bRx);
        compareRuns(aModel, bRx, runLength);
    endtask

    task automatic testCredits();
        int startModel;
        int startRx;
        checkValue("overrun", 0, overrun);
        consumerOn = 1'b0;
        startModel = modelLog.size();
        startRx    = rxCount;
        while (modelLog.size() - startModel < resultCredits + 1) sendSample(randomSample(), 0);
        idle(4);
        checkValue("resultsWithoutCredit", resultCredits, rxCount - startRx);
        checkValue("overrun", 1, overrun);
        if (expQ.size() != 1) begin
            $display("Dropped result was not the only one outstanding at %0t", $time);
            errors++;
        end else begin
            expQ.delete(0);
        end
        consumerOn = 1'b1;
        repeat (40) sendSample(randomSample(), 0);
        drainResults();
    endtask

    task automatic testControlPulses();
        int aModel;
        int runLength;
        int bRx;
        checkValue("overrun", 1, overrun);
        writeReg(`REG_CONTROL, controlWord(1'b0, 1'b1));
        idle(2);
        checkValue("overrun", 0, overrun);
        configure(18'h00001, 18'h00001, 18'h00014, 18'h3FFFF, 18'h00005, 18'h00012,
                  codePkg::singleLfsr);
        drainResults();
        burst.delete();
        repeat (70) burst.push_back(randomSample());
        aModel = modelLog.size();
        playBurst(1'b0);
        runLength = modelLog.size() - aModel;
        bRx = rxLog.size();
        playBurst(1'b0);
        checkValue("runLength", runLength, rxLog.size() - bRx);
        compareRuns(aModel, bRx, runLength);
    endtask

    initial begin
        #(watchdogNs);
        $display("Timeout after %0d ns, the tests did not finish", watchdogNs);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        regWrite    = 1'b0;
        regAddr     = '0;
        regData     = '0;
        sampleValid = 1'b0;
        sample      = '0;
        cfgInit     = '0;
        cfgEpoch    = '0;
        cfgPoly     = '0;
        cfgCount    = '0;
        cfgITaps    = '0;
        cfgQTaps    = '0;
        cfgMode     = codePkg::singleLfsr;
        mAccI       = 0;
        mAccQ       = 0;
        modelReload();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        testSingleMode();
        testGoldMode();
        testSampleGaps();
        testCredits();
        testControlPulses();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/despreader.sv
// *************************************************************************
// Despreader top: register decoder, code generator and chip correlator.
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module despreader #(
    parameter int codeWidth     = 18,
    parameter int resultCredits = 4
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                regWrite,
    input  wire logic [3:0]          regAddr,
    input  wire codePkg::codeState_t regData,
    input  wire logic                sampleValid,
    input  wire corrPkg::sampleIq_t  sample,
    input  wire logic                resultCredit,
    output logic                     resultValid,
    output corrPkg::corrResult_t     result,
    output logic                     overrun
);

    codePkg::codeConfig_t codeConfig;
    logic                 codeRestart;
    logic                 overrunClear;
    logic                 iChip;
    logic                 qChip;
    logic                 goldChip;
    logic                 codeEpoch;

    codeRegDecode regDecode (
        .clk          (clk),
        .reset        (reset),
        .regWrite     (regWrite),
        .regAddr      (regAddr),
        .regData      (regData),
        .codeConfig   (codeConfig),
        .codeRestart  (codeRestart),
        .overrunClear (overrunClear)
    );

    codeGen #(
        .codeWidth (codeWidth)
    ) codeGenerator (
        .clk         (clk),
        .reset       (reset),
        .codeRestart (codeRestart),
        .chipEnable  (sampleValid),                      // One chip per sample.
        .codeConfig  (codeConfig),
        .iChip       (iChip),
        .qChip       (qChip),
        .goldChip    (goldChip),
        .codeEpoch   (codeEpoch)
    );

    chipCorrelator #(
        .resultCredits (resultCredits)
    ) correlator (
        .clk          (clk),
        .reset        (reset),
        .sampleValid  (sampleValid),
        .sample       (sample),
        .iChip        (iChip),
        .qChip        (qChip),
        .goldChip     (goldChip),
        .codeEpoch    (codeEpoch),
        .mode         (codeConfig.mode),
        .overrunClear (overrunClear),
        .resultCredit (resultCredit),
        .resultValid  (resultValid),
        .result       (result),
        .overrun      (overrun)
    );

endmodule

`default_nettype wire

//--- rtl/chipCorrelator.sv
// *************************************************************************
// Chip correlator: sample delay, chip sign multiply, epoch accumulators
// and result hand-off under credit control with overrun detection.
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module chipCorrelator #(
    parameter int resultCredits = 4
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               sampleValid,
    input  wire corrPkg::sampleIq_t sample,
    input  wire logic               iChip,
    input  wire logic               qChip,
    input  wire logic               goldChip,
    input  wire logic               codeEpoch,
    input  wire codePkg::codeMode_t mode,
    input  wire logic               overrunClear,
    input  wire logic               resultCredit,
    output logic                    resultValid,
    output corrPkg::corrResult_t    result,
    output logic                    overrun
);

    localparam int creditBits = $clog2(resultCredits + 1);

    corrPkg::sampleIq_t    sampleD;
    logic                  sampleValidD;
    logic                  signI;
    logic                  signQ;
    corrPkg::acc_t         prodI;
    corrPkg::acc_t         prodQ;
    logic                  prodValid;
    logic                  prodEpoch;
    corrPkg::acc_t         accI;
    corrPkg::acc_t         accQ;
    logic [creditBits-1:0] credits;
    logic                  epochEnd;
    logic                  issue;

    // Chip 0 maps to +1, chip 1 to -1.
    function automatic corrPkg::acc_t applySign(
        input corrPkg::sample_t value,
        input logic             chip
    );
        corrPkg::acc_t ext;
        ext = corrPkg::acc_t'(value);
        return chip ? -ext : ext;
    endfunction

    assign signI = (mode == codePkg::goldCode) ? goldChip : iChip;
    assign signQ = (mode == codePkg::goldCode) ? goldChip : qChip;

    // Sample waits one cycle for its chips.
    always_ff @(posedge clk) begin
        sampleD <= sample;
        prodI   <= applySign(sampleD.sampleI, signI);
        prodQ   <= applySign(sampleD.sampleQ, signQ);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sampleValidD <= 1'b0;
            prodValid    <= 1'b0;
            prodEpoch    <= 1'b0;
        end else begin
            sampleValidD <= sampleValid;
            prodValid    <= sampleValidD;
            prodEpoch    <= sampleValidD & codeEpoch;
        end
    end

    assign epochEnd = prodValid & prodEpoch;
    assign issue    = epochEnd & (credits != '0);

    // Accumulate, closing the sums at each epoch chip.
    always_ff @(posedge clk) begin
        if (reset) begin
            accI <= '0;
            accQ <= '0;
        end else if (prodValid) begin
            accI <= prodEpoch ? prodI : accI + prodI;
            accQ <= prodEpoch ? prodQ : accQ + prodQ;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result.accI <= accI;
            result.accQ <= accQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            overrun     <= 1'b0;
            credits     <= creditBits'(resultCredits);
        end else begin
            resultValid <= issue;
            if (epochEnd && !issue) begin
                overrun <= 1'b1;                        // Result dropped.
            end else if (overrunClear) begin
                overrun <= 1'b0;
            end
            case ({issue, resultCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;                               // Spend and return cancel.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/codeGen.sv
// *************************************************************************
// Programmable PN/Gold code generator: primary and secondary LFSRs,
// restart counter, registered I/Q/Gold chips and epoch detection.
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module codeGen #(
    parameter int codeWidth = 18
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 codeRestart,
    input  wire logic                 chipEnable,
    input  wire codePkg::codeConfig_t codeConfig,
    output logic                      iChip,
    output logic                      qChip,
    output logic                      goldChip,
    output logic                      codeEpoch
);

    codePkg::codeState_t lfsr;
    codePkg::codeState_t secLfsr;
    codePkg::codeState_t restartCounter;
    logic                feedback;
    logic                secFeedback;
    logic                reload;
    logic                counterDone;

    // Modulo-2 sum of the selected state bits.
    function automatic logic parity(
        input codePkg::codeState_t state,
        input codePkg::codeState_t taps
    );
        logic sum;
        sum = 1'b0;
        for (int b = 0; b < codeWidth; b++) begin
            sum = sum ^ (state[b] & taps[b]);
        end
        return sum;
    endfunction

    assign feedback    = parity(lfsr, codeConfig.polyTaps);
    assign secFeedback = parity(secLfsr, codeConfig.qTaps);  // Gold partner polynomial.
    assign reload      = reset | codeRestart;
    assign counterDone = (restartCounter == '0);

    // Code state, advanced once per accepted sample.
    always_ff @(posedge clk) begin
        if (reload) begin
            lfsr           <= codeConfig.init;
            secLfsr        <= codeConfig.iTaps;              // Secondary seed.
            restartCounter <= codeConfig.restartCount;
        end else if (chipEnable) begin
            if (counterDone) begin
                lfsr           <= codeConfig.init;
                secLfsr        <= codeConfig.iTaps;
                restartCounter <= codeConfig.restartCount;
            end else begin
                lfsr           <= {lfsr[codeWidth-2:0], feedback};
                secLfsr        <= {secLfsr[codeWidth-2:0], secFeedback};
                restartCounter <= restartCounter - 1'b1;
            end
        end
    end

    // Chip outputs belong to the state before the shift.
    always_ff @(posedge clk) begin
        if (reset) begin
            iChip     <= 1'b0;
            qChip     <= 1'b0;
            goldChip  <= 1'b0;
            codeEpoch <= 1'b0;
        end else if (chipEnable) begin
            iChip     <= parity(lfsr, codeConfig.iTaps);
            qChip     <= parity(lfsr, codeConfig.qTaps);
            goldChip  <= lfsr[codeConfig.goldTap] ^ secLfsr[codeConfig.goldTap];
            codeEpoch <= ((lfsr & codeConfig.mask) == codeConfig.epoch);
        end
    end

endmodule

`default_nettype wire

//--- rtl/codeRegDecode.sv
// *************************************************************************
// Host write decoder: code configuration registers, mask and Gold tap
// derivation, and the restart and overrun-clear pulses.
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "codeRegMap.svh"

module codeRegDecode (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                regWrite,
    input  wire logic [3:0]          regAddr,
    input  wire codePkg::codeState_t regData,
    output codePkg::codeConfig_t     codeConfig,
    output logic                     codeRestart,
    output logic                     overrunClear
);

    codePkg::codeState_t maskNext;
    codePkg::tapIndex_t  tapNext;

    // Priority encode the taps being written.
    always_comb begin
        maskNext = '0;
        tapNext  = '0;
        for (int b = 0; b < codePkg::CODE_WIDTH; b++) begin
            if (regData[b]) begin
                tapNext = codePkg::tapIndex_t'(b);      // Highest set bit wins.
            end
            maskNext[b] = |(regData >> b);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            codeConfig   <= '0;
            codeRestart  <= 1'b0;
            overrunClear <= 1'b0;
        end else begin
            codeRestart  <= 1'b0;                        // Pulses last one cycle.
            overrunClear <= 1'b0;
            if (regWrite) begin
                case (regAddr)
                    `REG_INIT:          codeConfig.init         <= regData;
                    `REG_EPOCH:         codeConfig.epoch        <= regData;
                    `REG_RESTART_COUNT: codeConfig.restartCount <= regData;
                    `REG_I_TAPS:        codeConfig.iTaps        <= regData;
                    `REG_Q_TAPS:        codeConfig.qTaps        <= regData;
                    `REG_POLY_TAPS: begin
                        codeConfig.polyTaps <= regData;
                        codeConfig.mask     <= maskNext;
                        codeConfig.goldTap  <= tapNext;
                    end
                    `REG_CONTROL: begin
                        codeConfig.mode <= codePkg::codeMode_t'(regData[`CTRL_MODE_BIT]);
                        codeRestart     <= regData[`CTRL_RESTART_BIT];
                        overrunClear    <= regData[`CTRL_OVR_CLEAR_BIT];
                    end
                    default: ;                           // Unmapped address.
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/corrPkg.sv
// *************************************************************************
// Correlation types: sample and accumulator words, the complex sample
// and the I/Q result handed to the consumer.
// *************************************************************************
`default_nettype none

package corrPkg;

    localparam int SAMPLE_WIDTH = 8;
    localparam int ACC_WIDTH    = 24;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;

    typedef struct packed {
        sample_t sampleI;
        sample_t sampleQ;
    } sampleIq_t;

    // One epoch of despread energy.
    typedef struct packed {
        acc_t accI;
        acc_t accQ;
    } corrResult_t;

endpackage

`default_nettype wire

//--- rtl/codePkg.sv
// *************************************************************************
// Code generator types: chip-state vector, tap index, code mode and the
// decoded code configuration that drives the LFSRs.
// *************************************************************************
`default_nettype none

package codePkg;

    localparam int CODE_WIDTH      = 18;
    localparam int TAP_INDEX_WIDTH = $clog2(CODE_WIDTH);

    // LFSR state, taps, init, epoch, mask and restart count.
    typedef logic [CODE_WIDTH-1:0] codeState_t;

    typedef logic [TAP_INDEX_WIDTH-1:0] tapIndex_t;

    typedef enum logic {
        singleLfsr = 1'b0,          // I and Q from two tap sets on one LFSR.
        goldCode   = 1'b1           // Second LFSR XORed with the first.
    } codeMode_t;

    typedef struct packed {
        codeState_t init;           // Primary LFSR load value.
        codeState_t epoch;          // Phase that flags a code epoch.
        codeState_t polyTaps;       // Primary feedback polynomial.
        codeState_t restartCount;   // Chips between reloads, minus one.
        codeState_t iTaps;          // I output taps, secondary seed.
        codeState_t qTaps;          // Q output taps, secondary polynomial.
        codeState_t mask;           // Ones up to the highest polyTaps bit.
        tapIndex_t  goldTap;        // Index of that highest bit.
        codeMode_t  mode;
    } codeConfig_t;

endpackage

`default_nettype wire

//--- include/codeRegMap.svh
// *************************************************************************
// Host register address map and CONTROL register bit positions.
// *************************************************************************
`ifndef CODE_REG_MAP_SVH
`define CODE_REG_MAP_SVH

`define REG_INIT           4'h0
`define REG_EPOCH          4'h1
`define REG_POLY_TAPS      4'h2
`define REG_RESTART_COUNT  4'h3
`define REG_I_TAPS         4'h4
`define REG_Q_TAPS         4'h5
`define REG_CONTROL        4'h6

// CONTROL fields.
`define CTRL_MODE_BIT      0
`define CTRL_RESTART_BIT   1
`define CTRL_OVR_CLEAR_BIT 2

`endif
